// ==== source/axi_pkg.sv ====
package axi_pkg;

   // Bus widths of the single-beat master
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 64;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;

   // Byte address on AW and AR
   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

   // Full data beat on W and R
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // One strobe bit per byte lane
   typedef logic [AXI_STRB_W-1:0] axi_strb_t;

   // AxSIZE, log2 of the bytes in the beat
   typedef logic [2:0] axi_size_t;

   // BRESP and RRESP code
   typedef logic [1:0] axi_resp_t;

   // Anything other than OKAY is reported as an error
   localparam axi_resp_t RESP_OKAY = 2'b00;

   // Master FSM
   // ADDR drives AW or AR, DATA drives W, RESP waits on B or R
   typedef enum logic [1:0]
   {
      S_IDLE,
      S_ADDR,
      S_DATA,
      S_RESP
   } axi_state_t;

endpackage

// ==== source/dbg_pkg.sv ====
package dbg_pkg;

   // Width of data_i and data_o on the debug side
   localparam int DBG_DATA_W = 64;

   // Word size code as sent by the debug unit, in bytes
   typedef logic [3:0] word_size_t;

   localparam word_size_t WS_BYTE = 4'd1;
   localparam word_size_t WS_HALF = 4'd2;
   localparam word_size_t WS_WORD = 4'd4;

   typedef logic [DBG_DATA_W-1:0] dbg_data_t;

   // Lane decode of one request
   // lane is the lowest selected byte lane
   typedef struct packed
   {
      axi_pkg::axi_strb_t strb;
      axi_pkg::axi_size_t size;
      logic [2:0]         lane;
   } lane_dec_t;

   // Captured request, crosses from tck to the AXI clock
   // Held stable while a transfer is in flight
   typedef struct packed
   {
      axi_pkg::axi_addr_t addr;
      axi_pkg::axi_data_t wdata;
      axi_pkg::axi_strb_t strb;
      axi_pkg::axi_size_t size;
      logic               write;
   } dbg_req_t;

endpackage

// ==== source/toggle_sync.sv ====
`timescale 1ns/1ps

module toggle_sync
(
   input  logic clk_i,
   input  logic rstn_i,
   input  logic tgl_i,
   output logic pulse_o
);

   // Two synchronizing stages
   logic sync_q1;
   logic sync_q2;

   // Previous synchronized level for edge detection
   logic sync_q3;

   always_ff @(posedge clk_i or negedge rstn_i)
   begin
      if (!rstn_i)
      begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
         sync_q3 <= 1'b0;
      end
      else
      begin
         sync_q1 <= tgl_i;
         sync_q2 <= sync_q1;
         sync_q3 <= sync_q2;
      end
   end

   // Any change of the toggle gives a single-cycle pulse
   // 2 to 3 destination edges after the source flips
   assign pulse_o = sync_q2 ^ sync_q3;

endmodule

// ==== source/dbg_req_capture.sv ====
`timescale 1ns/1ps

module dbg_req_capture
(
   input  logic                tck_i,
   input  logic                trstn_i,
   input  logic                strobe_i,
   input  logic                rd_wrn_i,
   input  axi_pkg::axi_addr_t  addr_i,
   input  dbg_pkg::dbg_data_t  data_i,
   input  dbg_pkg::word_size_t word_size_i,
   input  logic                done_i,
   output dbg_pkg::dbg_req_t   req_o,
   output logic                req_tgl_o,
   output logic                rdy_o
);

   // Decoded lanes of the pending strobe
   dbg_pkg::lane_dec_t dec;

   // Lane mask before it is moved up to the addressed lane
   axi_pkg::axi_strb_t lane_mask;

   // Bit position of the meaningful bytes inside data_i
   logic [5:0] top_shift;

   // Write data moved onto its lanes
   axi_pkg::axi_data_t placed;

   logic accept;

   // Strobes while busy are dropped
   assign accept = strobe_i && rdy_o;

   //////////////////////////////////////////////////////////////////////
   // Lane decode and write data placement

   always_comb
   begin
      case (word_size_i)
         dbg_pkg::WS_BYTE:
         begin
            dec.size  = 3'd0;
            dec.lane  = addr_i[2:0];
            lane_mask = 8'h01;
            top_shift = 6'd56;
         end
         dbg_pkg::WS_HALF:
         begin
            dec.size  = 3'd1;
            dec.lane  = {addr_i[2:1], 1'b0};
            lane_mask = 8'h03;
            top_shift = 6'd48;
         end
         dbg_pkg::WS_WORD:
         begin
            dec.size  = 3'd2;
            dec.lane  = {addr_i[2], 2'b00};
            lane_mask = 8'h0f;
            top_shift = 6'd32;
         end
         default:
         begin
            // 8 bytes, and any unknown code, use the whole beat
            dec.size  = 3'd3;
            dec.lane  = 3'd0;
            lane_mask = 8'hff;
            top_shift = 6'd0;
         end
      endcase
      dec.strb = lane_mask << dec.lane;
   end

   // Short words arrive big-endian at the top of data_i
   // Bring them down to bit 0, then up to the first selected lane
   assign placed = (data_i >> top_shift) << {dec.lane, 3'b000};

   //////////////////////////////////////////////////////////////////////
   // Request register and handshake

   // Payload only changes on acceptance
   always_ff @(posedge tck_i)
   begin
      if (accept)
      begin
         req_o.addr  <= addr_i;
         req_o.wdata <= placed;
         req_o.strb  <= dec.strb;
         req_o.size  <= dec.size;
         req_o.write <= !rd_wrn_i;
      end
   end

   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
      begin
         req_tgl_o <= 1'b0;
         rdy_o     <= 1'b1;
      end
      else
      begin
         // One flip per request starts one AXI transfer
         if (accept)
         begin
            req_tgl_o <= ~req_tgl_o;
            rdy_o     <= 1'b0;
         end
         else if (done_i)
            rdy_o <= 1'b1;
      end
   end

   // Busy from the edge after acceptance
   a_accept_busy: assert property (
      @(posedge tck_i) disable iff (!trstn_i)
      accept |=> !rdy_o
   );

   // A completion only comes back for a request in flight
   a_done_when_busy: assert property (
      @(posedge tck_i) disable iff (!trstn_i)
      done_i |-> !rdy_o
   );

endmodule

// ==== source/axi_single_master.sv ====
`timescale 1ns/1ps

module axi_single_master
(
   input  logic               axi_aclk,
   input  logic               axi_aresetn,
   input  logic               start_i,
   input  dbg_pkg::dbg_req_t  req_i,
   // Write address
   output logic               axi_master_aw_valid_o,
   output axi_pkg::axi_addr_t axi_master_aw_addr_o,
   output axi_pkg::axi_size_t axi_master_aw_size_o,
   input  logic               axi_master_aw_ready_i,
   // Write data
   output logic               axi_master_w_valid_o,
   output axi_pkg::axi_data_t axi_master_w_data_o,
   output axi_pkg::axi_strb_t axi_master_w_strb_o,
   input  logic               axi_master_w_ready_i,
   // Read address
   output logic               axi_master_ar_valid_o,
   output axi_pkg::axi_addr_t axi_master_ar_addr_o,
   output axi_pkg::axi_size_t axi_master_ar_size_o,
   input  logic               axi_master_ar_ready_i,
   // Read data
   input  logic               axi_master_r_valid_i,
   input  axi_pkg::axi_data_t axi_master_r_data_i,
   input  axi_pkg::axi_resp_t axi_master_r_resp_i,
   output logic               axi_master_r_ready_o,
   // Write response
   input  logic               axi_master_b_valid_i,
   input  axi_pkg::axi_resp_t axi_master_b_resp_i,
   output logic               axi_master_b_ready_o,
   // Results back to the debug side
   output dbg_pkg::dbg_data_t rdata_o,
   output logic               err_o,
   output logic               done_tgl_o
);

   axi_pkg::axi_state_t state;
   axi_pkg::axi_state_t state_nxt;

   // Response handshake ends the transfer
   logic finish;

   // Lowest byte lane of the request
   logic [2:0] low_lane;

   axi_pkg::axi_data_t rdata_aligned;

   //////////////////////////////////////////////////////////////////////
   // FSM

   always_comb
   begin
      state_nxt = state;
      case (state)
         axi_pkg::S_IDLE:
         begin
            if (start_i)
               state_nxt = axi_pkg::S_ADDR;
         end
         axi_pkg::S_ADDR:
         begin
            // Reads skip the data phase
            if (req_i.write && axi_master_aw_ready_i)
               state_nxt = axi_pkg::S_DATA;
            else if (!req_i.write && axi_master_ar_ready_i)
               state_nxt = axi_pkg::S_RESP;
         end
         axi_pkg::S_DATA:
         begin
            if (axi_master_w_ready_i)
               state_nxt = axi_pkg::S_RESP;
         end
         default:
         begin
            if (finish)
               state_nxt = axi_pkg::S_IDLE;
         end
      endcase
   end

   // Valids and readies straight from the state
   assign axi_master_aw_valid_o = (state == axi_pkg::S_ADDR) && req_i.write;
   assign axi_master_ar_valid_o = (state == axi_pkg::S_ADDR) && !req_i.write;
   assign axi_master_w_valid_o  = (state == axi_pkg::S_DATA);
   assign axi_master_b_ready_o  = (state == axi_pkg::S_RESP) && req_i.write;
   assign axi_master_r_ready_o  = (state == axi_pkg::S_RESP) && !req_i.write;

   assign finish = (axi_master_b_ready_o && axi_master_b_valid_i) ||
                   (axi_master_r_ready_o && axi_master_r_valid_i);

   // Payload comes from the held request
   assign axi_master_aw_addr_o = req_i.addr;
   assign axi_master_ar_addr_o = req_i.addr;
   assign axi_master_aw_size_o = req_i.size;
   assign axi_master_ar_size_o = req_i.size;
   assign axi_master_w_data_o  = req_i.wdata;
   assign axi_master_w_strb_o  = req_i.strb;

   //////////////////////////////////////////////////////////////////////
   // Read alignment

   // Scan from the top so the lowest set strobe wins
   always_comb
   begin
      low_lane = 3'd0;
      for (int i = axi_pkg::AXI_STRB_W - 1; i >= 0; i--)
      begin
         if (req_i.strb[i])
            low_lane = 3'(i);
      end
   end

   assign rdata_aligned = axi_master_r_data_i >> {low_lane, 3'b000};

   //////////////////////////////////////////////////////////////////////
   // State, result registers and completion toggle

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
      begin
         state      <= axi_pkg::S_IDLE;
         rdata_o    <= '0;
         err_o      <= 1'b0;
         done_tgl_o <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (finish)
         begin
            done_tgl_o <= ~done_tgl_o;
            // Error from whichever channel closed the transfer
            if (req_i.write)
               err_o <= (axi_master_b_resp_i != axi_pkg::RESP_OKAY);
            else
            begin
               err_o   <= (axi_master_r_resp_i != axi_pkg::RESP_OKAY);
               rdata_o <= rdata_aligned;
            end
         end
      end
   end

   // Valid and payload hold until accepted
   a_aw_hold: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn)
      axi_master_aw_valid_o && !axi_master_aw_ready_i |=>
         axi_master_aw_valid_o && $stable(axi_master_aw_addr_o) &&
         $stable(axi_master_aw_size_o)
   );

   a_w_hold: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn)
      axi_master_w_valid_o && !axi_master_w_ready_i |=>
         axi_master_w_valid_o && $stable(axi_master_w_data_o) &&
         $stable(axi_master_w_strb_o)
   );

   a_ar_hold: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn)
      axi_master_ar_valid_o && !axi_master_ar_ready_i |=>
         axi_master_ar_valid_o && $stable(axi_master_ar_addr_o) &&
         $stable(axi_master_ar_size_o)
   );

   // Debug side never starts a new request while one is in flight
   a_start_idle: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn)
      start_i |-> state == axi_pkg::S_IDLE
   );

endmodule

// ==== source/adbg_axi_biu.sv ====
`timescale 1ns/1ps

module adbg_axi_biu
(
   // Debug unit, tck domain
   input  logic                tck_i,
   input  logic                trstn_i,
   input  dbg_pkg::dbg_data_t  data_i,
   output dbg_pkg::dbg_data_t  data_o,
   input  axi_pkg::axi_addr_t  addr_i,
   input  logic                strobe_i,
   // Low for a write
   input  logic                rd_wrn_i,
   output logic                rdy_o,
   output logic                err_o,
   input  dbg_pkg::word_size_t word_size_i,
   // AXI clock and reset
   input  logic                axi_aclk,
   input  logic                axi_aresetn,
   // AXI master outputs
   output logic                axi_master_aw_valid_o,
   output axi_pkg::axi_addr_t  axi_master_aw_addr_o,
   output axi_pkg::axi_size_t  axi_master_aw_size_o,
   output logic                axi_master_w_valid_o,
   output axi_pkg::axi_data_t  axi_master_w_data_o,
   output axi_pkg::axi_strb_t  axi_master_w_strb_o,
   output logic                axi_master_ar_valid_o,
   output axi_pkg::axi_addr_t  axi_master_ar_addr_o,
   output axi_pkg::axi_size_t  axi_master_ar_size_o,
   output logic                axi_master_r_ready_o,
   output logic                axi_master_b_ready_o,
   // AXI master inputs
   input  logic                axi_master_aw_ready_i,
   input  logic                axi_master_w_ready_i,
   input  logic                axi_master_ar_ready_i,
   input  logic                axi_master_r_valid_i,
   input  axi_pkg::axi_data_t  axi_master_r_data_i,
   input  axi_pkg::axi_resp_t  axi_master_r_resp_i,
   input  logic                axi_master_b_valid_i,
   input  axi_pkg::axi_resp_t  axi_master_b_resp_i
);

   // Request held in the tck domain, read in the AXI domain
   dbg_pkg::dbg_req_t req;

   // Toggles across the domains and their pulses
   logic req_tgl;
   logic start;
   logic done_tgl;
   logic done;

   //////////////////////////////////////////////////////////////////////
   // tck domain

   dbg_req_capture u_capture
   (
      .tck_i       (tck_i),
      .trstn_i     (trstn_i),
      .strobe_i    (strobe_i),
      .rd_wrn_i    (rd_wrn_i),
      .addr_i      (addr_i),
      .data_i      (data_i),
      .word_size_i (word_size_i),
      .done_i      (done),
      .req_o       (req),
      .req_tgl_o   (req_tgl),
      .rdy_o       (rdy_o)
   );

   // Completion back into tck
   toggle_sync u_done_sync
   (
      .clk_i   (tck_i),
      .rstn_i  (trstn_i),
      .tgl_i   (done_tgl),
      .pulse_o (done)
   );

   //////////////////////////////////////////////////////////////////////
   // AXI domain

   // Request start into the AXI clock
   toggle_sync u_start_sync
   (
      .clk_i   (axi_aclk),
      .rstn_i  (axi_aresetn),
      .tgl_i   (req_tgl),
      .pulse_o (start)
   );

   // rdata and err stay quasi-static until the next completion
   axi_single_master u_master
   (
      .axi_aclk              (axi_aclk),
      .axi_aresetn           (axi_aresetn),
      .start_i               (start),
      .req_i                 (req),
      .axi_master_aw_valid_o (axi_master_aw_valid_o),
      .axi_master_aw_addr_o  (axi_master_aw_addr_o),
      .axi_master_aw_size_o  (axi_master_aw_size_o),
      .axi_master_aw_ready_i (axi_master_aw_ready_i),
      .axi_master_w_valid_o  (axi_master_w_valid_o),
      .axi_master_w_data_o   (axi_master_w_data_o),
      .axi_master_w_strb_o   (axi_master_w_strb_o),
      .axi_master_w_ready_i  (axi_master_w_ready_i),
      .axi_master_ar_valid_o (axi_master_ar_valid_o),
      .axi_master_ar_addr_o  (axi_master_ar_addr_o),
      .axi_master_ar_size_o  (axi_master_ar_size_o),
      .axi_master_ar_ready_i (axi_master_ar_ready_i),
      .axi_master_r_valid_i  (axi_master_r_valid_i),
      .axi_master_r_data_i   (axi_master_r_data_i),
      .axi_master_r_resp_i   (axi_master_r_resp_i),
      .axi_master_r_ready_o  (axi_master_r_ready_o),
      .axi_master_b_valid_i  (axi_master_b_valid_i),
      .axi_master_b_resp_i   (axi_master_b_resp_i),
      .axi_master_b_ready_o  (axi_master_b_ready_o),
      .rdata_o               (data_o),
      .err_o                 (err_o),
      .done_tgl_o            (done_tgl)
   );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
#(
   parameter realtime PERIOD_NS = 10.0
)
(
   output logic clk_o,
   output logic rstn_o
);

   // Free running clock, low at time zero
   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   // Reset held over the first 5 rising edges
   initial
   begin
      rstn_o = 1'b0;
      repeat (5) @(posedge clk_o);
      #1;
      rstn_o = 1'b1;
   end

endmodule

// ==== sim/tb_adbg_axi_biu.sv ====
`timescale 1ns/1ps

module tb_adbg_axi_biu;

   // Limit from about 40 accesses at about 30 tck cycles each
   localparam int TIMEOUT_CYCLES = 2000;
   localparam axi_pkg::axi_resp_t RESP_SLVERR = 2'b10;

   // Expected view of the request in flight
   typedef struct packed
   {
      axi_pkg::axi_addr_t addr;
      axi_pkg::axi_size_t size;
      axi_pkg::axi_strb_t strb;
      axi_pkg::axi_data_t wdata;
      dbg_pkg::dbg_data_t rdata;
      dbg_pkg::dbg_data_t rmask;
      logic               err;
      logic               write;
   } model_t;

   logic tck;
   logic trstn;
   logic axi_aclk;
   logic axi_aresetn;

   // Debug side
   dbg_pkg::dbg_data_t  data_in;
   dbg_pkg::dbg_data_t  data_out;
   axi_pkg::axi_addr_t  addr;
   logic                strobe;
   logic                rd_wrn;
   logic                rdy;
   logic                err;
   dbg_pkg::word_size_t word_size;

   // AXI side
   logic               aw_valid;
   axi_pkg::axi_addr_t aw_addr;
   axi_pkg::axi_size_t aw_size;
   logic               aw_ready;
   logic               w_valid;
   axi_pkg::axi_data_t w_data;
   axi_pkg::axi_strb_t w_strb;
   logic               w_ready;
   logic               ar_valid;
   axi_pkg::axi_addr_t ar_addr;
   axi_pkg::axi_size_t ar_size;
   logic               ar_ready;
   logic               r_valid;
   axi_pkg::axi_data_t r_data;
   axi_pkg::axi_resp_t r_resp;
   logic               r_ready;
   logic               b_valid;
   axi_pkg::axi_resp_t b_resp;
   logic               b_ready;

   model_t model;
   int     errors = 0;
   int     n_access = 0;
   int     tck_cycles = 0;
   integer seed = 65680;

   // Set once an address handshake happened for the current request
   logic addr_seen;

   // Sparse slave memory, one byte per address
   logic [7:0] mem [axi_pkg::axi_addr_t];

   tb_clk_gen #(.PERIOD_NS(10.0)) u_axi_clk (.clk_o(axi_aclk), .rstn_o(axi_aresetn));
   tb_clk_gen #(.PERIOD_NS(26.0)) u_tck_clk (.clk_o(tck), .rstn_o(trstn));

   adbg_axi_biu UUT
   (
      .tck_i                 (tck),
      .trstn_i               (trstn),
      .data_i                (data_in),
      .data_o                (data_out),
      .addr_i                (addr),
      .strobe_i              (strobe),
      .rd_wrn_i              (rd_wrn),
      .rdy_o                 (rdy),
      .err_o                 (err),
      .word_size_i           (word_size),
      .axi_aclk              (axi_aclk),
      .axi_aresetn           (axi_aresetn),
      .axi_master_aw_valid_o (aw_valid),
      .axi_master_aw_addr_o  (aw_addr),
      .axi_master_aw_size_o  (aw_size),
      .axi_master_w_valid_o  (w_valid),
      .axi_master_w_data_o   (w_data),
      .axi_master_w_strb_o   (w_strb),
      .axi_master_ar_valid_o (ar_valid),
      .axi_master_ar_addr_o  (ar_addr),
      .axi_master_ar_size_o  (ar_size),
      .axi_master_r_ready_o  (r_ready),
      .axi_master_b_ready_o  (b_ready),
      .axi_master_aw_ready_i (aw_ready),
      .axi_master_w_ready_i  (w_ready),
      .axi_master_ar_ready_i (ar_ready),
      .axi_master_r_valid_i  (r_valid),
      .axi_master_r_data_i   (r_data),
      .axi_master_r_resp_i   (r_resp),
      .axi_master_b_valid_i  (b_valid),
      .axi_master_b_resp_i   (b_resp)
   );

   ////////////////////////////////////////////////////////////////////////
   // Reference model

   function automatic int unsigned byte_count(input dbg_pkg::word_size_t ws);
      if (ws == 4'd1 || ws == 4'd2 || ws == 4'd4)
         return ws;
      // Unknown codes count as a full beat
      return 8;
   endfunction

   // Address offset rounded down to the access size
   function automatic int unsigned first_lane(input dbg_pkg::word_size_t ws,
                                              input axi_pkg::axi_addr_t a);
      return (a % 8) / byte_count(ws) * byte_count(ws);
   endfunction

   function automatic model_t build_model(input logic write, input dbg_pkg::word_size_t ws,
                                          input axi_pkg::axi_addr_t a,
                                          input dbg_pkg::dbg_data_t data,
                                          input logic check_data);
      model_t m;
      int unsigned n;
      int unsigned lane;
      n = byte_count(ws);
      lane = first_lane(ws, a);
      m = '0;
      m.addr = a;
      m.size = 3'($clog2(n));
      m.write = write;
      m.err = a[31];
      // Byte b counts up from the least significant of the top n bytes of data
      for (int b = 0; b < n; b++)
      begin
         m.strb[lane + b] = 1'b1;
         m.wdata[(lane + b) * 8 +: 8] = data[(8 - n + b) * 8 +: 8];
         if (check_data)
         begin
            m.rdata[b * 8 +: 8] = data[(8 - n + b) * 8 +: 8];
            m.rmask[b * 8 +: 8] = 8'hff;
         end
      end
      return m;
   endfunction

   // Contents of never written bytes
   function automatic logic [7:0] fill_byte(input axi_pkg::axi_addr_t a);
      return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
   endfunction

   function automatic int unsigned rand_delay();
      return $unsigned($random(seed)) % 4;
   endfunction

   task automatic log_error(input string msg);
      errors++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   task automatic axi_step();
      @(posedge axi_aclk);
      #1;
   endtask

   task automatic tck_step();
      @(posedge tck);
      #1;
   endtask

   ////////////////////////////////////////////////////////////////////////
   // AXI slave model

   task automatic serve_write();
      axi_pkg::axi_addr_t a;
      a = aw_addr;
      repeat (rand_delay()) axi_step();
      aw_ready = 1'b1;
      axi_step();
      aw_ready = 1'b0;
      while (!w_valid) axi_step();
      repeat (rand_delay()) axi_step();
      w_ready = 1'b1;
      // Error region keeps no data
      for (int l = 0; l < 8; l++)
      begin
         if (w_strb[l] && !a[31])
            mem[{a[31:3], 3'(l)}] = w_data[l * 8 +: 8];
      end
      axi_step();
      w_ready = 1'b0;
      repeat (rand_delay()) axi_step();
      b_resp = a[31] ? RESP_SLVERR : axi_pkg::RESP_OKAY;
      b_valid = 1'b1;
      while (!b_ready) axi_step();
      axi_step();
      b_valid = 1'b0;
   endtask

   task automatic serve_read();
      axi_pkg::axi_addr_t a;
      axi_pkg::axi_addr_t ba;
      a = ar_addr;
      repeat (rand_delay()) axi_step();
      ar_ready = 1'b1;
      axi_step();
      ar_ready = 1'b0;
      repeat (rand_delay()) axi_step();
      // Whole beat from the word holding the address
      for (int l = 0; l < 8; l++)
      begin
         ba = {a[31:3], 3'(l)};
         r_data[l * 8 +: 8] = mem.exists(ba) ? mem[ba] : fill_byte(ba);
      end
      r_resp = a[31] ? RESP_SLVERR : axi_pkg::RESP_OKAY;
      r_valid = 1'b1;
      while (!r_ready) axi_step();
      axi_step();
      r_valid = 1'b0;
   endtask

   initial
   begin
      aw_ready = 1'b0;
      w_ready = 1'b0;
      ar_ready = 1'b0;
      r_valid = 1'b0;
      r_data = '0;
      r_resp = axi_pkg::RESP_OKAY;
      b_valid = 1'b0;
      b_resp = axi_pkg::RESP_OKAY;
      forever
      begin
         axi_step();
         if (aw_valid)
            serve_write();
         else if (ar_valid)
            serve_read();
      end
   end

   always @(posedge axi_aclk)
   begin
      if ((aw_valid && aw_ready) || (ar_valid && ar_ready))
         addr_seen <= 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////
   // Checks

   a_rdy_drop: assert property (@(posedge tck) disable iff (!trstn)
      strobe && rdy |=> !rdy)
      else log_error("rdy_o still high after an accepted strobe");

   a_aw_payload: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      aw_valid |-> model.write && aw_addr == model.addr && aw_size == model.size)
      else log_error("AW address or size differs from the request");

   a_w_payload: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      w_valid |-> w_strb == model.strb && w_data == model.wdata)
      else log_error("W strobe or lane-placed data differs from the request");

   a_ar_payload: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      ar_valid |-> !model.write && ar_addr == model.addr && ar_size == model.size)
      else log_error("AR address or size differs from the request");

   // Valid and payload hold under back-pressure
   a_aw_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_size))
      else log_error("AW valid or payload changed before ready");

   a_w_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
      else log_error("W valid or payload changed before ready");

   a_ar_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_size))
      else log_error("AR valid or payload changed before ready");

   a_single_addr: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      (aw_valid && aw_ready) || (ar_valid && ar_ready) |-> !addr_seen)
      else log_error("second address issued for one request");

   // Results are sampled one tck edge after completion
   a_rdata: assert property (@(posedge tck) disable iff (!trstn)
      $rose(rdy) && !model.write |-> ((data_out ^ model.rdata) & model.rmask) == '0)
      else log_error("read data not aligned to the low bits of data_o");

   a_err: assert property (@(posedge tck) disable iff (!trstn)
      $rose(rdy) |-> err == model.err)
      else log_error("err_o differs from the slave response");

   ////////////////////////////////////////////////////////////////////////
   // Request driver

   task automatic access(input logic write, input dbg_pkg::word_size_t ws,
                         input axi_pkg::axi_addr_t a, input dbg_pkg::dbg_data_t data,
                         input logic check_data);
      model = build_model(write, ws, a, data, check_data);
      addr_seen = 1'b0;
      strobe = 1'b1;
      rd_wrn = !write;
      word_size = ws;
      addr = a;
      data_in = write ? data : '0;
      tck_step();
      strobe = 1'b0;
      while (!rdy) tck_step();
      // Keep the model until the completion checks have sampled it
      tck_step();
      n_access++;
   endtask

   // Write random data, then read it back at the same size
   task automatic write_read(input dbg_pkg::word_size_t ws, input axi_pkg::axi_addr_t a);
      dbg_pkg::dbg_data_t d;
      d = {$random(seed), $random(seed)};
      access(1'b1, ws, a, d, 1'b0);
      access(1'b0, ws, a, d, 1'b1);
   endtask

   initial
   begin
      strobe = 1'b0;
      rd_wrn = 1'b1;
      word_size = 4'd8;
      addr = '0;
      data_in = '0;
      addr_seen = 1'b0;
      model = '0;
      wait (trstn && axi_aresetn);
      tck_step();
      a_reset_state: assert (rdy && !err && data_out == '0 && !aw_valid && !w_valid &&
                             !ar_valid && !r_ready && !b_ready)
         else log_error("outputs not at their reset values");
      // Every legal offset of each size
      for (int off = 0; off < 8; off++)
         write_read(4'd1, 32'h0000_1000 + off);
      for (int off = 0; off < 8; off += 2)
         write_read(4'd2, 32'h0000_2000 + off);
      for (int off = 0; off < 8; off += 4)
         write_read(4'd4, 32'h0000_3000 + off);
      write_read(4'd8, 32'h0000_4000);
      // Upper half of the map answers SLVERR
      access(1'b1, 4'd4, 32'h8000_0010, {$random(seed), $random(seed)}, 1'b0);
      access(1'b0, 4'd4, 32'h8000_0014, '0, 1'b0);
      write_read(4'd2, 32'h0000_5006);
      // Unknown size codes
      write_read(4'd3, 32'h0000_6000);
      write_read(4'd15, 32'h0000_6008);
      $display("Accesses: %0d, errors: %0d", n_access, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   always @(posedge tck)
   begin
      tck_cycles++;
      if (tck_cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: accesses did not finish within %0d tck cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

endmodule

// ==== build.f ====
source/axi_pkg.sv
source/dbg_pkg.sv
source/toggle_sync.sv
source/dbg_req_capture.sv
source/axi_single_master.sv
source/adbg_axi_biu.sv
sim/tb_clk_gen.sv
sim/tb_adbg_axi_biu.sv
